// File: Bender.yml
package:
  name: mem_subsys

sources:
  - mem_pkg.sv
  - sram_axi_slave.sv
  - axi_lite_arbiter.sv
  - mem_subsys_top.sv
  - target: simulation
    files:
      - mem_subsys_checker.sv
      - tb_mem_subsys.sv

// File: axi_lite_arbiter.sv
module axi_lite_arbiter (
	input  logic                       clk,
	input  logic                       rst,

	// instruction fetch master, read only
	input  logic                       if_arvalid,
	input  logic [mem_pkg::ADDR_W-1:0] if_araddr,
	output logic                       if_arready,
	output logic                       if_rvalid,
	output logic [mem_pkg::DATA_W-1:0] if_rdata,
	output logic [1:0]                 if_rresp,
	input  logic                       if_rready,

	// load-store master, read channels
	input  logic                       ls_arvalid,
	input  logic [mem_pkg::ADDR_W-1:0] ls_araddr,
	output logic                       ls_arready,
	output logic                       ls_rvalid,
	output logic [mem_pkg::DATA_W-1:0] ls_rdata,
	output logic [1:0]                 ls_rresp,
	input  logic                       ls_rready,

	// load-store master, write channels
	input  logic                       ls_awvalid,
	input  logic [mem_pkg::ADDR_W-1:0] ls_awaddr,
	output logic                       ls_awready,
	input  logic                       ls_wvalid,
	input  logic [mem_pkg::DATA_W-1:0] ls_wdata,
	input  logic [mem_pkg::STRB_W-1:0] ls_wstrb,
	output logic                       ls_wready,
	output logic                       ls_bvalid,
	output logic [1:0]                 ls_bresp,
	input  logic                       ls_bready,

	// toward the memory slave
	output logic                       s_arvalid,
	output logic [mem_pkg::ADDR_W-1:0] s_araddr,
	input  logic                       s_arready,
	input  logic                       s_rvalid,
	input  logic [mem_pkg::DATA_W-1:0] s_rdata,
	input  logic [1:0]                 s_rresp,
	output logic                       s_rready,
	output logic                       s_awvalid,
	output logic [mem_pkg::ADDR_W-1:0] s_awaddr,
	input  logic                       s_awready,
	output logic                       s_wvalid,
	output logic [mem_pkg::DATA_W-1:0] s_wdata,
	output logic [mem_pkg::STRB_W-1:0] s_wstrb,
	input  logic                       s_wready,
	input  logic                       s_bvalid,
	input  logic [1:0]                 s_bresp,
	output logic                       s_bready
);

	// round-robin state, set when load-store won the last grant
	logic rr_last_ls;
	// read path locked from AR transfer to R transfer
	logic rd_busy;
	// who owns the read in flight
	logic rd_owner_ls;

	// combinational pick among the requesters
	logic sel_ls;
	logic grant_if;
	logic grant_ls;
	logic ar_fire;
	logic r_fire;

	// load-store wins if it asks alone
	// or if both ask and fetch went last
	assign sel_ls = ls_arvalid && (!if_arvalid || !rr_last_ls);

	// nothing new goes out while a read is owned
	assign grant_ls = !rd_busy && sel_ls;
	assign grant_if = !rd_busy && if_arvalid && !sel_ls;

	// AR forward
	assign s_arvalid = grant_if || grant_ls;
	assign s_araddr  = sel_ls ? ls_araddr : if_araddr;

	// only the granted master sees arready
	assign if_arready = grant_if && s_arready;
	assign ls_arready = grant_ls && s_arready;

	assign ar_fire = s_arvalid && s_arready;

	// R return, valid steered to the owner only
	assign if_rvalid = s_rvalid && rd_busy && !rd_owner_ls;
	assign ls_rvalid = s_rvalid && rd_busy && rd_owner_ls;

	// payload can go to both, valid decides who takes it
	assign if_rdata = s_rdata;
	assign if_rresp = s_rresp;
	assign ls_rdata = s_rdata;
	assign ls_rresp = s_rresp;

	// ready taken from the owner
	assign s_rready = rd_busy && (rd_owner_ls ? ls_rready : if_rready);

	assign r_fire = s_rvalid && s_rready;

	// owner tracking and round-robin update
	always_ff @(posedge clk) begin
		if (rst) begin
			// fetch counts as last winner, load-store goes first
			rr_last_ls  <= 1'b0;
			rd_busy     <= 1'b0;
			rd_owner_ls <= 1'b0;
		end else begin
			if (ar_fire) begin
				rd_busy     <= 1'b1;
				rd_owner_ls <= sel_ls;
				rr_last_ls  <= sel_ls;
			end else if (r_fire) begin
				// slave is idle again next cycle, so is the lock
				rd_busy <= 1'b0;
			end
		end
	end

	// write path
	// only load-store writes, so no arbitration and no added cycle
	assign s_awvalid  = ls_awvalid;
	assign s_awaddr   = ls_awaddr;
	assign ls_awready = s_awready;

	assign s_wvalid  = ls_wvalid;
	assign s_wdata   = ls_wdata;
	assign s_wstrb   = ls_wstrb;
	assign ls_wready = s_wready;

	assign ls_bvalid = s_bvalid;
	assign ls_bresp  = s_bresp;
	assign s_bready  = ls_bready;

endmodule

// File: mem_pkg.sv
package mem_pkg;

	// bus widths for both master ports and the slave
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;

	// one strobe per byte lane
	localparam int STRB_W = DATA_W / 8;

	// low address bits that select a byte inside a doubleword
	localparam int BYTE_OFFS_W = $clog2(STRB_W);

	// on-chip memory window
	// first mapped byte
	localparam logic [ADDR_W-1:0] MEM_BASE = 32'h8000_0000;

	// doublewords in the array
	localparam int MEM_WORDS = 512;

	// word index width into the array
	localparam int IDX_W = $clog2(MEM_WORDS);

	// window size in bytes (4 KiB)
	localparam logic [ADDR_W-1:0] MEM_BYTES = ADDR_W'(MEM_WORDS * STRB_W);

	// axi response codes
	localparam logic [1:0] RESP_OKAY = 2'b00;
	// nothing mapped at this address
	localparam logic [1:0] RESP_DECERR = 2'b11;

	// slave channel machines only have two states
	// waiting for a request
	localparam logic ST_IDLE = 1'b0;
	// response valid, waiting for ready
	localparam logic ST_RESP = 1'b1;

	// one stored doubleword
	// whole view on the read path
	// lane view for strobed byte merges
	typedef union packed {
		logic [DATA_W-1:0]      word;
		logic [STRB_W-1:0][7:0] lane;
	} dword_t;

endpackage

// File: mem_subsys_checker.sv
module mem_subsys_checker (
	input logic                       clk,
	input logic                       rst,
	input logic                       arvalid,
	input logic                       arready,
	input logic                       rvalid,
	input logic [mem_pkg::DATA_W-1:0] rdata,
	input logic [1:0]                 rresp,
	input logic                       rready,
	input logic                       bvalid,
	input logic [1:0]                 bresp,
	input logic                       bready
);

	// read response holds with its payload until taken
	a_r_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else $error("read response changed before rready");

	// same for the write response
	a_b_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("write response changed before bready");

	// an accepted read address is answered on the next cycle
	a_r_latency: assert property (@(posedge clk) disable iff (rst)
		arvalid && arready |=> rvalid)
		else $error("rvalid missing one cycle after the read address transfer");

	// responses clear right after reset
	a_rst_clear: assert property (@(posedge clk)
		rst |=> !rvalid && !bvalid)
		else $error("response valid in the cycle after reset");

endmodule

bind sram_axi_slave mem_subsys_checker chk0 (.*);

// File: mem_subsys_top.sv
module mem_subsys_top (
	input  logic                       clk,
	input  logic                       rst,

	// instruction fetch port
	input  logic                       if_arvalid,
	input  logic [mem_pkg::ADDR_W-1:0] if_araddr,
	output logic                       if_arready,
	output logic                       if_rvalid,
	output logic [mem_pkg::DATA_W-1:0] if_rdata,
	output logic [1:0]                 if_rresp,
	input  logic                       if_rready,

	// load-store port
	input  logic                       ls_arvalid,
	input  logic [mem_pkg::ADDR_W-1:0] ls_araddr,
	output logic                       ls_arready,
	output logic                       ls_rvalid,
	output logic [mem_pkg::DATA_W-1:0] ls_rdata,
	output logic [1:0]                 ls_rresp,
	input  logic                       ls_rready,
	input  logic                       ls_awvalid,
	input  logic [mem_pkg::ADDR_W-1:0] ls_awaddr,
	output logic                       ls_awready,
	input  logic                       ls_wvalid,
	input  logic [mem_pkg::DATA_W-1:0] ls_wdata,
	input  logic [mem_pkg::STRB_W-1:0] ls_wstrb,
	output logic                       ls_wready,
	output logic                       ls_bvalid,
	output logic [1:0]                 ls_bresp,
	input  logic                       ls_bready
);
	import mem_pkg::*;

	// arbiter to slave link
	logic              s_arvalid;
	logic [ADDR_W-1:0] s_araddr;
	logic              s_arready;
	logic              s_rvalid;
	logic [DATA_W-1:0] s_rdata;
	logic [1:0]        s_rresp;
	logic              s_rready;
	logic              s_awvalid;
	logic [ADDR_W-1:0] s_awaddr;
	logic              s_awready;
	logic              s_wvalid;
	logic [DATA_W-1:0] s_wdata;
	logic [STRB_W-1:0] s_wstrb;
	logic              s_wready;
	logic              s_bvalid;
	logic [1:0]        s_bresp;
	logic              s_bready;

	// two masters in, one slave port out
	axi_lite_arbiter arb0 (
		.clk        (clk),
		.rst        (rst),
		.if_arvalid (if_arvalid),
		.if_araddr  (if_araddr),
		.if_arready (if_arready),
		.if_rvalid  (if_rvalid),
		.if_rdata   (if_rdata),
		.if_rresp   (if_rresp),
		.if_rready  (if_rready),
		.ls_arvalid (ls_arvalid),
		.ls_araddr  (ls_araddr),
		.ls_arready (ls_arready),
		.ls_rvalid  (ls_rvalid),
		.ls_rdata   (ls_rdata),
		.ls_rresp   (ls_rresp),
		.ls_rready  (ls_rready),
		.ls_awvalid (ls_awvalid),
		.ls_awaddr  (ls_awaddr),
		.ls_awready (ls_awready),
		.ls_wvalid  (ls_wvalid),
		.ls_wdata   (ls_wdata),
		.ls_wstrb   (ls_wstrb),
		.ls_wready  (ls_wready),
		.ls_bvalid  (ls_bvalid),
		.ls_bresp   (ls_bresp),
		.ls_bready  (ls_bready),
		.s_arvalid  (s_arvalid),
		.s_araddr   (s_araddr),
		.s_arready  (s_arready),
		.s_rvalid   (s_rvalid),
		.s_rdata    (s_rdata),
		.s_rresp    (s_rresp),
		.s_rready   (s_rready),
		.s_awvalid  (s_awvalid),
		.s_awaddr   (s_awaddr),
		.s_awready  (s_awready),
		.s_wvalid   (s_wvalid),
		.s_wdata    (s_wdata),
		.s_wstrb    (s_wstrb),
		.s_wready   (s_wready),
		.s_bvalid   (s_bvalid),
		.s_bresp    (s_bresp),
		.s_bready   (s_bready)
	);

	// on-chip memory
	sram_axi_slave sram0 (
		.clk     (clk),
		.rst     (rst),
		.arvalid (s_arvalid),
		.araddr  (s_araddr),
		.arready (s_arready),
		.rvalid  (s_rvalid),
		.rdata   (s_rdata),
		.rresp   (s_rresp),
		.rready  (s_rready),
		.awvalid (s_awvalid),
		.awaddr  (s_awaddr),
		.awready (s_awready),
		.wvalid  (s_wvalid),
		.wdata   (s_wdata),
		.wstrb   (s_wstrb),
		.wready  (s_wready),
		.bvalid  (s_bvalid),
		.bresp   (s_bresp),
		.bready  (s_bready)
	);

endmodule

// File: sim.f
mem_pkg.sv
sram_axi_slave.sv
axi_lite_arbiter.sv
mem_subsys_top.sv
mem_subsys_checker.sv
tb_mem_subsys.sv

// File: sram_axi_slave.sv
module sram_axi_slave (
	input  logic                       clk,
	input  logic                       rst,

	// read address channel
	input  logic                       arvalid,
	input  logic [mem_pkg::ADDR_W-1:0] araddr,
	output logic                       arready,

	// read data channel
	output logic                       rvalid,
	output logic [mem_pkg::DATA_W-1:0] rdata,
	output logic [1:0]                 rresp,
	input  logic                       rready,

	// write address channel
	input  logic                       awvalid,
	input  logic [mem_pkg::ADDR_W-1:0] awaddr,
	output logic                       awready,

	// write data channel
	input  logic                       wvalid,
	input  logic [mem_pkg::DATA_W-1:0] wdata,
	input  logic [mem_pkg::STRB_W-1:0] wstrb,
	output logic                       wready,

	// write response channel
	output logic                       bvalid,
	output logic [1:0]                 bresp,
	input  logic                       bready
);
	import mem_pkg::*;

	// doubleword array covering the whole window
	dword_t mem [MEM_WORDS];

	// read machine
	logic              rd_state;
	// byte offset of araddr from the window base
	logic [ADDR_W-1:0] rd_offs;
	logic              rd_hit;
	logic [IDX_W-1:0]  rd_idx;
	logic              ar_fire;
	logic              r_fire;

	// write machine
	logic              wr_state;
	logic [ADDR_W-1:0] wr_offs;
	logic              wr_hit;
	logic [IDX_W-1:0]  wr_idx;
	logic              wr_fire;
	logic              b_fire;
	// write data seen through the lane view
	dword_t            wr_data;

	// window decode
	// addresses below the base wrap to a large offset and miss
	assign rd_offs = araddr - MEM_BASE;
	assign rd_hit  = rd_offs < MEM_BYTES;
	// byte bits inside the doubleword are dropped
	assign rd_idx  = rd_offs[BYTE_OFFS_W +: IDX_W];

	assign wr_offs = awaddr - MEM_BASE;
	assign wr_hit  = wr_offs < MEM_BYTES;
	assign wr_idx  = wr_offs[BYTE_OFFS_W +: IDX_W];

	// read side
	// only accept an address while idle, one read in flight
	assign arready = (rd_state == ST_IDLE);
	// rvalid comes straight from the state flop
	assign rvalid  = (rd_state == ST_RESP);
	assign ar_fire = arvalid && arready;
	assign r_fire  = rvalid && rready;

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= ST_IDLE;
		end else begin
			case (rd_state)
				ST_IDLE: begin
					if (ar_fire) begin
						rd_state <= ST_RESP;
					end
				end
				ST_RESP: begin
					// hold until the master takes it
					if (r_fire) begin
						rd_state <= ST_IDLE;
					end
				end
				default: begin
					rd_state <= ST_IDLE;
				end
			endcase
		end
	end

	// read payload, captured on the address transfer
	// stays put while rvalid waits on rready
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			if (rd_hit) begin
				rdata <= mem[rd_idx].word;
				rresp <= RESP_OKAY;
			end else begin
				// unmapped reads return zero
				rdata <= '0;
				rresp <= RESP_DECERR;
			end
		end
	end

	// write side
	// address and data only move together, and only from idle
	assign wr_fire = (wr_state == ST_IDLE) && awvalid && wvalid;
	assign awready = wr_fire;
	assign wready  = wr_fire;
	assign bvalid  = (wr_state == ST_RESP);
	assign b_fire  = bvalid && bready;

	assign wr_data = wdata;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_state <= ST_IDLE;
		end else begin
			case (wr_state)
				ST_IDLE: begin
					if (wr_fire) begin
						wr_state <= ST_RESP;
					end
				end
				ST_RESP: begin
					if (b_fire) begin
						wr_state <= ST_IDLE;
					end
				end
				default: begin
					wr_state <= ST_IDLE;
				end
			endcase
		end
	end

	// write response code, decided at the transfer
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			bresp <= wr_hit ? RESP_OKAY : RESP_DECERR;
		end
	end

	// strobe merge into the array
	// out of window writes are dropped here
	// a read on the same edge still sees the old word
	always_ff @(posedge clk) begin
		if (wr_fire && wr_hit) begin
			for (int i = 0; i < STRB_W; i++) begin
				if (wstrb[i]) begin
					mem[wr_idx].lane[i] <= wr_data.lane[i];
				end
			end
		end
	end

endmodule

// File: tb_mem_subsys.sv
module tb_mem_subsys;
	import mem_pkg::*;

	// clock period and reset length in cycles
	localparam int PERIOD  = 100;
	localparam int RST_CYC = 10;

	// lower half for fetch, upper half for load-store
	localparam int HALF = MEM_WORDS / 2;

	// transaction counts per phase
	localparam int N_PART = 32;
	localparam int N_CONC = 100;
	localparam int N_BP   = 16;
	localparam int N_OOW  = 8;

	// preload, partial, concurrent, back-pressure, out of window, final sweep
	localparam int N_TXN = MEM_WORDS + 2 * N_PART + 2 * N_CONC + 3 * N_BP + 2 * N_OOW + MEM_WORDS;
	// 20 cycles per transaction on top of reset
	localparam int WD_CYC = N_TXN * 20 + RST_CYC;

	// cycles a read address may wait on the other master with ready always high
	localparam int MAX_WAIT = 3;

	logic              clk;
	logic              rst;

	// fetch port
	logic              if_arvalid;
	logic [ADDR_W-1:0] if_araddr;
	logic              if_arready;
	logic              if_rvalid;
	logic [DATA_W-1:0] if_rdata;
	logic [1:0]        if_rresp;
	logic              if_rready;

	// load-store port
	logic              ls_arvalid;
	logic [ADDR_W-1:0] ls_araddr;
	logic              ls_arready;
	logic              ls_rvalid;
	logic [DATA_W-1:0] ls_rdata;
	logic [1:0]        ls_rresp;
	logic              ls_rready;
	logic              ls_awvalid;
	logic [ADDR_W-1:0] ls_awaddr;
	logic              ls_awready;
	logic              ls_wvalid;
	logic [DATA_W-1:0] ls_wdata;
	logic [STRB_W-1:0] ls_wstrb;
	logic              ls_wready;
	logic              ls_bvalid;
	logic [1:0]        ls_bresp;
	logic              ls_bready;

	integer seed;
	// random ready stretches when set
	bit     bp_on;
	// reference copy of the window
	dword_t model [MEM_WORDS];

	mem_subsys_top dut0 (.*);

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	function automatic logic [DATA_W-1:0] rand_dword();
		return {$random(seed), $random(seed)};
	endfunction

	// ready held low about three cycles in four under back-pressure
	function automatic logic pick_ready();
		if (!bp_on) begin
			return 1'b1;
		end
		return ($random(seed) & 3) == 0;
	endfunction

	// byte address of a word, low byte bits random since the slave ignores them
	function automatic logic [ADDR_W-1:0] word_addr(input int idx);
		return MEM_BASE + ADDR_W'(idx * STRB_W) + ADDR_W'($random(seed) & 7);
	endfunction

	// strobed byte-lane merge
	function automatic dword_t merge_bytes(input dword_t old_w, input dword_t new_w,
			input logic [STRB_W-1:0] strb);
		dword_t res;
		res = old_w;
		for (int i = 0; i < STRB_W; i++) begin
			if (strb[i]) begin
				res.lane[i] = new_w.lane[i];
			end
		end
		return res;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_data(input string name, input dword_t exp, input dword_t act);
		if (act !== exp) begin
			abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp) begin
			abort_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	// one read on either port
	// sampled a quarter period after the falling edge, before the next rising edge
	task automatic do_read(input bit use_ls, input logic [ADDR_W-1:0] addr,
			output dword_t data, output logic [1:0] resp);
		logic   granted;
		logic   rv;
		int     waits;
		dword_t first;
		waits = 0;
		@(negedge clk);
		if (use_ls) begin
			ls_arvalid = 1'b1;
			ls_araddr  = addr;
		end else begin
			if_arvalid = 1'b1;
			if_araddr  = addr;
		end
		#(PERIOD / 4);
		granted = use_ls ? ls_arready : if_arready;
		while (!granted) begin
			// nothing may come back before the address is taken
			rv = use_ls ? ls_rvalid : if_rvalid;
			if (rv) begin
				abort_run("rvalid came up before the read address was accepted");
			end
			@(negedge clk);
			waits++;
			// round-robin hands the next grant to the waiting master
			if (!bp_on && waits > MAX_WAIT) begin
				abort_run("read address starved, the arbiter did not alternate");
			end
			#(PERIOD / 4);
			granted = use_ls ? ls_arready : if_arready;
		end
		// address moves on the coming rising edge
		@(negedge clk);
		if (use_ls) begin
			ls_arvalid = 1'b0;
			ls_rready  = pick_ready();
		end else begin
			if_arvalid = 1'b0;
			if_rready  = pick_ready();
		end
		#(PERIOD / 4);
		rv = use_ls ? ls_rvalid : if_rvalid;
		if (!rv) begin
			abort_run("rvalid did not follow the read address transfer by one cycle");
		end
		first = use_ls ? ls_rdata : if_rdata;
		while (!(use_ls ? ls_rready : if_rready)) begin
			@(negedge clk);
			if (use_ls) begin
				ls_rready = pick_ready();
			end else begin
				if_rready = pick_ready();
			end
			#(PERIOD / 4);
			rv = use_ls ? ls_rvalid : if_rvalid;
			if (!rv) begin
				abort_run("rvalid dropped before the read response was accepted");
			end
			data = use_ls ? ls_rdata : if_rdata;
			check_data("read data held under back-pressure", first, data);
		end
		data = use_ls ? ls_rdata : if_rdata;
		resp = use_ls ? ls_rresp : if_rresp;
	endtask

	// one write on the load-store port
	task automatic do_write(input logic [ADDR_W-1:0] addr, input dword_t data,
			input logic [STRB_W-1:0] strb, output logic [1:0] resp);
		@(negedge clk);
		ls_awvalid = 1'b1;
		ls_wvalid  = 1'b1;
		ls_awaddr  = addr;
		ls_wdata   = data;
		ls_wstrb   = strb;
		#(PERIOD / 4);
		while (!(ls_awready && ls_wready)) begin
			if (ls_bvalid) begin
				abort_run("bvalid came up before the write was accepted");
			end
			@(negedge clk);
			#(PERIOD / 4);
		end
		@(negedge clk);
		ls_awvalid = 1'b0;
		ls_wvalid  = 1'b0;
		ls_bready  = pick_ready();
		#(PERIOD / 4);
		if (!ls_bvalid) begin
			abort_run("bvalid did not follow the write transfer by one cycle");
		end
		resp = ls_bresp;
		while (!ls_bready) begin
			@(negedge clk);
			ls_bready = pick_ready();
			#(PERIOD / 4);
			if (!ls_bvalid) begin
				abort_run("bvalid dropped before the write response was accepted");
			end
			check_resp("write response held under back-pressure", resp, ls_bresp);
		end
	endtask

	// in-window write, model follows the merge
	task automatic write_checked(input string name, input int idx,
			input logic [STRB_W-1:0] strb);
		dword_t     d;
		logic [1:0] resp;
		d = rand_dword();
		do_write(word_addr(idx), d, strb, resp);
		check_resp(name, RESP_OKAY, resp);
		model[idx] = merge_bytes(model[idx], d, strb);
	endtask

	task automatic read_checked(input string name, input bit use_ls, input int idx);
		dword_t     d;
		logic [1:0] resp;
		do_read(use_ls, word_addr(idx), d, resp);
		check_resp(name, RESP_OKAY, resp);
		check_data(name, model[idx], d);
	endtask

	// hang guard sized from the transaction count
	initial begin
		#(WD_CYC * PERIOD);
		$display("run hung: tests not finished after %0d cycles", WD_CYC);
		$display("Testbench failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		int                idx_list [N_PART];
		dword_t            d;
		logic [1:0]        resp;
		logic [ADDR_W-1:0] bad_addr;
		seed       = 32'hf488_a6b6;
		bp_on      = 1'b0;
		rst        = 1'b1;
		if_arvalid = 1'b0;
		if_araddr  = '0;
		if_rready  = 1'b0;
		ls_arvalid = 1'b0;
		ls_araddr  = '0;
		ls_rready  = 1'b0;
		ls_awvalid = 1'b0;
		ls_awaddr  = '0;
		ls_wvalid  = 1'b0;
		ls_wdata   = '0;
		ls_wstrb   = '0;
		ls_bready  = 1'b0;
		repeat (RST_CYC) @(negedge clk);
		rst = 1'b0;

		// fill the whole window, full strobes
		for (int i = 0; i < MEM_WORDS; i++) begin
			write_checked("preload", i, '1);
		end

		// strobed writes in the upper half, then read back
		for (int i = 0; i < N_PART; i++) begin
			idx_list[i] = HALF + ($unsigned($random(seed)) % HALF);
			write_checked("partial write", idx_list[i], STRB_W'($random(seed)));
		end
		for (int i = 0; i < N_PART; i++) begin
			read_checked("partial read", 1'b1, idx_list[i]);
		end

		// both masters reading at once, disjoint halves
		fork
			for (int i = 0; i < N_CONC; i++) begin
				read_checked("fetch read", 1'b0, $unsigned($random(seed)) % HALF);
			end
			for (int i = 0; i < N_CONC; i++) begin
				read_checked("load-store read", 1'b1, HALF + ($unsigned($random(seed)) % HALF));
			end
		join

		// random ready stretches on both ports
		bp_on = 1'b1;
		fork
			for (int i = 0; i < N_BP; i++) begin
				int idx;
				idx = HALF + ($unsigned($random(seed)) % HALF);
				write_checked("back-pressure write", idx, STRB_W'($random(seed)));
				read_checked("back-pressure read", 1'b1, idx);
			end
			for (int i = 0; i < N_BP; i++) begin
				read_checked("back-pressure fetch", 1'b0, $unsigned($random(seed)) % HALF);
			end
		join
		bp_on = 1'b0;

		// below the base on even steps, past the window on odd ones
		for (int i = 0; i < N_OOW; i++) begin
			if (i % 2 == 0) begin
				bad_addr = MEM_BASE - ADDR_W'(STRB_W * (1 + ($unsigned($random(seed)) % 64)));
			end else begin
				bad_addr = MEM_BASE + MEM_BYTES + ADDR_W'(STRB_W * ($unsigned($random(seed)) % 64));
			end
			do_write(bad_addr, rand_dword(), '1, resp);
			check_resp("out of window write", RESP_DECERR, resp);
			do_read(i % 2 == 1, bad_addr, d, resp);
			check_resp("out of window read", RESP_DECERR, resp);
			check_data("out of window read data", '0, d);
		end

		// nothing outside the model moved
		for (int i = 0; i < MEM_WORDS; i++) begin
			read_checked("window sweep", 1'b1, i);
		end

		$display("Testbench passed");
		$finish;
	end

endmodule
